// ==== split_cfg_pkg.sv ====
// split memory configuration
// widths, sizes and shared vector types

package split_cfg_pkg;

  localparam int unsigned NB_CHAN    = 4;                   // narrow channels
  localparam int unsigned WIDE_DW    = 128;
  localparam int unsigned WIDE_BW    = WIDE_DW / 8;         // strobes per wide word
  localparam int unsigned NARROW_DW  = WIDE_DW / NB_CHAN;
  localparam int unsigned NARROW_BW  = NARROW_DW / 8;

  // byte offset plus lane select inside a wide word
  localparam int unsigned LANE_BITS  = $clog2(WIDE_BW);

  localparam int unsigned AW         = 12;                  // byte address
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);

  // channel fifo sizing
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [AW-1:0]        addr_t;
  typedef logic [WIDE_DW-1:0]   wide_data_t;
  typedef logic [WIDE_BW-1:0]   wide_be_t;
  typedef logic [NARROW_DW-1:0] narrow_data_t;
  typedef logic [NARROW_BW-1:0] narrow_be_t;
  typedef logic [NB_CHAN-1:0]   chan_vec_t;     // grant, stall, valid vectors
  typedef logic [BANK_AW-1:0]   bank_addr_t;    // word index in a bank

endpackage

// ==== split_fsm_pkg.sv ====
// splitter state encodings

package split_fsm_pkg;

  // wide grant synchronizer
  typedef enum logic {
    GNT_SYNC,   // all lanes granted together
    GNT_SKEW    // some lanes still pending
  } gnt_state_e;

  // wide response synchronizer
  typedef enum logic {
    RSP_SYNC,   // lane responses aligned
    RSP_SKEW    // waiting on late lanes
  } rsp_state_e;

endpackage

// ==== tcdm_bank.sv ====
`timescale 1ns/1ps
// narrow memory bank

module tcdm_bank (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        wen_i,     // high for read
  input  split_cfg_pkg::bank_addr_t   addr_i,
  input  split_cfg_pkg::narrow_be_t   be_i,
  input  split_cfg_pkg::narrow_data_t wdata_i,
  input  logic                        stall_i,   // external contention
  input  logic                        r_ready_i,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output split_cfg_pkg::narrow_data_t r_data_o
);

  import split_cfg_pkg::*;

  narrow_data_t mem_q [BANK_WORDS];
  narrow_data_t r_data_q;
  logic         r_valid_q;
  logic         rsp_busy;    // response not taken yet

  assign rsp_busy  = r_valid_q & ~r_ready_i;
  assign gnt_o     = req_i & ~stall_i & ~rsp_busy;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

  // byte-wise write, read data registered
  always_ff @(posedge clk_i) begin
    if (gnt_o && !wen_i) begin
      for (int b = 0; b < NARROW_BW; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
    if (gnt_o && wen_i) begin
      r_data_q <= mem_q[addr_i];
    end
  end

  // response held until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (gnt_o && wen_i) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

endmodule

// ==== chan_fifo.sv ====
`timescale 1ns/1ps
// channel request and response FIFOs

module chan_fifo (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        lane_req_i,
  input  logic                        lane_wen_i,
  input  split_cfg_pkg::addr_t        lane_addr_i,
  input  split_cfg_pkg::narrow_be_t   lane_be_i,
  input  split_cfg_pkg::narrow_data_t lane_wdata_i,
  output logic                        lane_gnt_o,       // request fifo not full
  output logic                        lane_r_valid_o,
  output split_cfg_pkg::narrow_data_t lane_r_data_o,
  input  logic                        lane_r_ready_i,
  output logic                        bank_req_o,
  output logic                        bank_wen_o,
  output split_cfg_pkg::bank_addr_t   bank_addr_o,
  output split_cfg_pkg::narrow_be_t   bank_be_o,
  output split_cfg_pkg::narrow_data_t bank_wdata_o,
  input  logic                        bank_gnt_i,
  input  logic                        bank_r_valid_i,
  input  split_cfg_pkg::narrow_data_t bank_r_data_i,
  output logic                        bank_r_ready_o    // response fifo not full
);

  import split_cfg_pkg::*;

  logic                  req_wen_q   [FIFO_DEPTH];
  bank_addr_t            req_addr_q  [FIFO_DEPTH];
  narrow_be_t            req_be_q    [FIFO_DEPTH];
  narrow_data_t          req_wdata_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] req_wr_q, req_rd_q;
  logic [FIFO_CNT_W-1:0] req_cnt_q;
  logic                  req_push, req_pop;

  narrow_data_t          rsp_data_q  [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] rsp_wr_q, rsp_rd_q;
  logic [FIFO_CNT_W-1:0] rsp_cnt_q;
  logic                  rsp_push, rsp_pop;

  // circular pointer step
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    return (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // request fifo
  assign lane_gnt_o = (req_cnt_q != FIFO_CNT_W'(FIFO_DEPTH));
  assign req_push   = lane_req_i & lane_gnt_o;
  assign bank_req_o = (req_cnt_q != '0);
  assign req_pop    = bank_req_o & bank_gnt_i;

  assign bank_wen_o   = req_wen_q[req_rd_q];
  assign bank_addr_o  = req_addr_q[req_rd_q];
  assign bank_be_o    = req_be_q[req_rd_q];
  assign bank_wdata_o = req_wdata_q[req_rd_q];

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      req_wen_q[req_wr_q]   <= lane_wen_i;
      req_addr_q[req_wr_q]  <= lane_addr_i[LANE_BITS +: BANK_AW];  // word index only
      req_be_q[req_wr_q]    <= lane_be_i;
      req_wdata_q[req_wr_q] <= lane_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_wr_q  <= '0;
      req_rd_q  <= '0;
      req_cnt_q <= '0;
    end else if (clear_i) begin
      req_wr_q  <= '0;
      req_rd_q  <= '0;
      req_cnt_q <= '0;
    end else begin
      if (req_push) req_wr_q <= ptr_inc(req_wr_q);
      if (req_pop) req_rd_q <= ptr_inc(req_rd_q);
      if (req_push && !req_pop) req_cnt_q <= req_cnt_q + 1'b1;
      else if (req_pop && !req_push) req_cnt_q <= req_cnt_q - 1'b1;
    end
  end

  // response fifo
  assign bank_r_ready_o = (rsp_cnt_q != FIFO_CNT_W'(FIFO_DEPTH));
  assign rsp_push       = bank_r_valid_i & bank_r_ready_o;
  assign lane_r_valid_o = (rsp_cnt_q != '0);
  assign rsp_pop        = lane_r_valid_o & lane_r_ready_i;
  assign lane_r_data_o  = rsp_data_q[rsp_rd_q];

  always_ff @(posedge clk_i) begin
    if (rsp_push) begin
      rsp_data_q[rsp_wr_q] <= bank_r_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_wr_q  <= '0;
      rsp_rd_q  <= '0;
      rsp_cnt_q <= '0;
    end else if (clear_i) begin
      rsp_wr_q  <= '0;
      rsp_rd_q  <= '0;
      rsp_cnt_q <= '0;
    end else begin
      if (rsp_push) rsp_wr_q <= ptr_inc(rsp_wr_q);
      if (rsp_pop) rsp_rd_q <= ptr_inc(rsp_rd_q);
      if (rsp_push && !rsp_pop) rsp_cnt_q <= rsp_cnt_q + 1'b1;
      else if (rsp_pop && !rsp_push) rsp_cnt_q <= rsp_cnt_q - 1'b1;
    end
  end

endmodule

// ==== wide_port_split.sv ====
`timescale 1ns/1ps
// wide port splitter
// lane slicing with grant and response lock-step

module wide_port_split (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  input  logic                                              req_i,
  input  logic                                              wen_i,      // high for read
  input  split_cfg_pkg::addr_t                              addr_i,
  input  split_cfg_pkg::wide_be_t                           be_i,
  input  split_cfg_pkg::wide_data_t                         wdata_i,
  input  logic                                              r_ready_i,
  output logic                                              gnt_o,
  output logic                                              r_valid_o,
  output split_cfg_pkg::wide_data_t                         r_data_o,
  output split_cfg_pkg::chan_vec_t                          lane_req_o,
  output split_cfg_pkg::chan_vec_t                          lane_wen_o,
  output split_cfg_pkg::addr_t [split_cfg_pkg::NB_CHAN-1:0] lane_addr_o,
  output split_cfg_pkg::narrow_be_t [split_cfg_pkg::NB_CHAN-1:0]   lane_be_o,
  output split_cfg_pkg::narrow_data_t [split_cfg_pkg::NB_CHAN-1:0] lane_wdata_o,
  output split_cfg_pkg::chan_vec_t                          lane_r_ready_o,
  input  split_cfg_pkg::chan_vec_t                          lane_gnt_i,
  input  split_cfg_pkg::chan_vec_t                          lane_r_valid_i,
  input  split_cfg_pkg::narrow_data_t [split_cfg_pkg::NB_CHAN-1:0] lane_r_data_i
);

  import split_cfg_pkg::*;
  import split_fsm_pkg::*;

  gnt_state_e gnt_state_q, gnt_state_d;
  chan_vec_t  gnt_mask_q, gnt_mask_d;   // slices already pushed
  chan_vec_t  lane_acc;                 // slice taken this cycle
  logic       all_valid;

  // request slicing and response gathering
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_lane
    // masked lanes stay quiet until the wide grant
    assign lane_req_o[ii]   = (gnt_state_q == GNT_SYNC) ? req_i : req_i & ~gnt_mask_q[ii];
    assign lane_wen_o[ii]   = wen_i;
    assign lane_addr_o[ii]  = addr_i + addr_t'(ii * NARROW_BW);
    assign lane_be_o[ii]    = be_i[ii*NARROW_BW +: NARROW_BW];
    assign lane_wdata_o[ii] = wdata_i[ii*NARROW_DW +: NARROW_DW];
    assign r_data_o[ii*NARROW_DW +: NARROW_DW] = lane_r_data_i[ii];  // lane 0 in low bits
  end

  assign lane_acc = lane_req_o & lane_gnt_i;

  // mask is clear in GNT_SYNC so this covers both states
  assign gnt_o = req_i & (&(lane_gnt_i | gnt_mask_q));

  // grant synchronizer
  always_comb begin
    gnt_state_d = gnt_state_q;
    gnt_mask_d  = gnt_mask_q;
    case (gnt_state_q)
      GNT_SYNC: begin
        if (req_i && !gnt_o) begin      // at least one lane refused
          gnt_state_d = GNT_SKEW;
          gnt_mask_d  = lane_acc;       // remember the early ones
        end
      end
      GNT_SKEW: begin
        if (gnt_o) begin
          gnt_state_d = GNT_SYNC;
          gnt_mask_d  = '0;
        end else begin
          gnt_mask_d  = gnt_mask_q | lane_acc;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_state_q <= GNT_SYNC;
      gnt_mask_q  <= '0;
    end else if (clear_i) begin
      gnt_state_q <= GNT_SYNC;
      gnt_mask_q  <= '0;
    end else begin
      gnt_state_q <= gnt_state_d;
      gnt_mask_q  <= gnt_mask_d;
    end
  end

  // response side, all lanes pop in the same cycle
  assign all_valid      = &lane_r_valid_i;
  assign r_valid_o      = all_valid;
  assign lane_r_ready_o = {NB_CHAN{r_ready_i & all_valid}};

endmodule

// ==== split_mem_top.sv ====
`timescale 1ns/1ps
// split memory subsystem top

module split_mem_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  logic                      wen_i,
  input  split_cfg_pkg::addr_t      addr_i,
  input  split_cfg_pkg::wide_be_t   be_i,
  input  split_cfg_pkg::wide_data_t wdata_i,
  input  logic                      r_ready_i,
  input  split_cfg_pkg::chan_vec_t  stall_i,    // one bit per bank
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output split_cfg_pkg::wide_data_t r_data_o
);

  import split_cfg_pkg::*;

  // splitter to fifo
  chan_vec_t                  lane_req, lane_wen, lane_gnt, lane_r_valid, lane_r_ready;
  addr_t        [NB_CHAN-1:0] lane_addr;
  narrow_be_t   [NB_CHAN-1:0] lane_be;
  narrow_data_t [NB_CHAN-1:0] lane_wdata, lane_r_data;

  // fifo to bank
  chan_vec_t                  bank_req, bank_wen, bank_gnt, bank_r_valid, bank_r_ready;
  bank_addr_t   [NB_CHAN-1:0] bank_addr;
  narrow_be_t   [NB_CHAN-1:0] bank_be;
  narrow_data_t [NB_CHAN-1:0] bank_wdata, bank_r_data;

  wide_port_split i_split (
    .clk_i, .rst_ni, .clear_i,
    .req_i, .wen_i, .addr_i, .be_i, .wdata_i, .r_ready_i,
    .gnt_o, .r_valid_o, .r_data_o,
    .lane_req_o     ( lane_req     ),
    .lane_wen_o     ( lane_wen     ),
    .lane_addr_o    ( lane_addr    ),
    .lane_be_o      ( lane_be      ),
    .lane_wdata_o   ( lane_wdata   ),
    .lane_r_ready_o ( lane_r_ready ),
    .lane_gnt_i     ( lane_gnt     ),
    .lane_r_valid_i ( lane_r_valid ),
    .lane_r_data_i  ( lane_r_data  )
  );

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    chan_fifo i_fifo (
      .clk_i, .rst_ni, .clear_i,
      .lane_req_i     ( lane_req[ii]     ),
      .lane_wen_i     ( lane_wen[ii]     ),
      .lane_addr_i    ( lane_addr[ii]    ),
      .lane_be_i      ( lane_be[ii]      ),
      .lane_wdata_i   ( lane_wdata[ii]   ),
      .lane_gnt_o     ( lane_gnt[ii]     ),
      .lane_r_valid_o ( lane_r_valid[ii] ),
      .lane_r_data_o  ( lane_r_data[ii]  ),
      .lane_r_ready_i ( lane_r_ready[ii] ),
      .bank_req_o     ( bank_req[ii]     ),
      .bank_wen_o     ( bank_wen[ii]     ),
      .bank_addr_o    ( bank_addr[ii]    ),
      .bank_be_o      ( bank_be[ii]      ),
      .bank_wdata_o   ( bank_wdata[ii]   ),
      .bank_gnt_i     ( bank_gnt[ii]     ),
      .bank_r_valid_i ( bank_r_valid[ii] ),
      .bank_r_data_i  ( bank_r_data[ii]  ),
      .bank_r_ready_o ( bank_r_ready[ii] )
    );

    tcdm_bank i_bank (
      .clk_i, .rst_ni,
      .req_i     ( bank_req[ii]     ),
      .wen_i     ( bank_wen[ii]     ),
      .addr_i    ( bank_addr[ii]    ),
      .be_i      ( bank_be[ii]      ),
      .wdata_i   ( bank_wdata[ii]   ),
      .stall_i   ( stall_i[ii]      ),
      .r_ready_i ( bank_r_ready[ii] ),
      .gnt_o     ( bank_gnt[ii]     ),
      .r_valid_o ( bank_r_valid[ii] ),
      .r_data_o  ( bank_r_data[ii]  )
    );
  end

endmodule

// ==== tb_split_mem.sv ====
`timescale 1ns/1ps
// split memory testbench

module tb_split_mem;

  import split_cfg_pkg::*;
  import split_fsm_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int TOTAL_OPS  = 280;     // sum of all issued requests below
  localparam int WORDS      = BANK_WORDS;

  logic       clk_i, rst_ni, clear_i, req_i, wen_i, r_ready_i;
  addr_t      addr_i;
  wide_be_t   be_i;
  wide_data_t wdata_i, r_data_o;
  chan_vec_t  stall_i;
  logic       gnt_o, r_valid_o;

  wide_data_t model [WORDS];           // reference copy of all wide words
  wide_data_t exp_q [$];               // reads granted, oldest first
  logic [31:0] lfsr_q = 32'd77;
  string      cur_test;
  int         test_err, rd_cnt, rsp_cnt, pass_cnt, fail_cnt;
  int         ready_mode;              // 0 high, 1 held low, 2 random
  logic       stall_en;

  split_mem_top i_split_mem_top (
    .clk_i, .rst_ni, .clear_i, .req_i, .wen_i, .addr_i, .be_i, .wdata_i,
    .r_ready_i, .stall_i, .gnt_o, .r_valid_o, .r_data_o
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) lfsr_q ^= 32'h80200003;
    return lsb;
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[126:0], rand_bit()};  // one step per bit
    return v;
  endfunction

  task automatic compare_data(input string name, input wide_data_t exp, input wide_data_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      test_err++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      test_err++;
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch %s response count: expected %0d, actual %0d", name, exp, act);
      test_err++;
    end
  endtask

  // background stall and ready drivers
  initial begin
    stall_i   = '0;
    r_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #2;
      stall_i = stall_en ? chan_vec_t'(rand_bits(NB_CHAN)) : '0;
      case (ready_mode)
        0: r_ready_i = 1'b1;
        1: r_ready_i = 1'b0;
        default: r_ready_i = rand_bit();
      endcase
    end
  end

  // response monitor, taken at the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni && r_valid_o && r_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: response arrived with no read outstanding", cur_test);
        test_err++;
      end else begin
        compare_data(cur_test, exp_q.pop_front(), r_data_o);
      end
      rsp_cnt++;
    end
  end

  // one wide request, returns at the negedge before its grant edge
  task automatic issue(input logic rd, input int idx, input wide_be_t be, input wide_data_t wd);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    wen_i   = rd;
    addr_i  = addr_t'(idx * WIDE_BW);  // wide aligned
    be_i    = be;
    wdata_i = wd;
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
    if (rd) begin
      exp_q.push_back(model[idx]);
      rd_cnt++;
    end else begin
      for (int b = 0; b < WIDE_BW; b++) begin
        if (be[b]) model[idx][b*8 +: 8] = wd[b*8 +: 8];
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      req_i = 1'b0;
    end
    @(negedge clk_i);
  endtask

  task automatic drain();
    int guard;
    guard = 0;
    idle(1);
    while (exp_q.size() != 0 && guard < 500) begin
      @(negedge clk_i);
      guard++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d read responses never arrived", cur_test, exp_q.size());
      test_err++;
      exp_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
    rd_cnt   = 0;
    rsp_cnt  = 0;
  endtask

  task automatic finish_test();
    compare_count(cur_test, rd_cnt, rsp_cnt);
    if (test_err == 0) begin
      pass_cnt++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", cur_test, test_err);
    end
  endtask

  task automatic test_backpressure();
    int   low_run;
    int   guard;
    logic dropped;
    start_test("backpressure");
    ready_mode = 1;
    dropped    = 1'b0;
    low_run    = 0;
    guard      = 0;
    fork
      begin
        for (int n = 0; n < 16; n++) issue(1'b1, int'(rand_bits(6)), '0, '0);
        idle(1);
      end
      begin
        // ten refused cycles in a row count as a dropped grant
        while (!dropped && guard < 400) begin
          @(negedge clk_i);
          guard++;
          low_run = (req_i && !gnt_o) ? low_run + 1 : 0;
          if (low_run >= 10) dropped = 1'b1;
        end
        ready_mode = 2;            // release, random back-pressure
      end
    join
    compare_bit("backpressure gnt drop", 1'b1, dropped);
    drain();
    finish_test();
  endtask

  // watchdog
  initial begin
    #(TOTAL_OPS * 40 * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles", TOTAL_OPS * 40);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    req_i      = 1'b0;
    wen_i      = 1'b0;
    addr_i     = '0;
    be_i       = '0;
    wdata_i    = '0;
    ready_mode = 0;
    stall_en   = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;

    start_test("reset");
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_bit("reset gnt_o", 1'b0, gnt_o);
    compare_bit("reset r_valid_o", 1'b0, r_valid_o);
    compare_bit("reset gnt state", 1'b1, i_split_mem_top.i_split.gnt_state_q == GNT_SYNC);
    $display("  state after reset: %s", i_split_mem_top.i_split.gnt_state_q.name());
    finish_test();

    // fills every word, later tests read defined data
    start_test("full_word");
    for (int i = 0; i < WORDS; i++) issue(1'b0, i, '1, wide_data_t'(rand_bits(WIDE_DW)));
    for (int i = 0; i < 32; i++) issue(1'b1, int'(rand_bits(6)), '0, '0);
    drain();
    finish_test();

    start_test("partial_strobe");
    for (int i = 0; i < 48; i++) begin
      issue(1'b0, int'(rand_bits(6)), wide_be_t'(rand_bits(WIDE_BW)),
            wide_data_t'(rand_bits(WIDE_DW)));
    end
    for (int i = 0; i < 24; i++) issue(1'b1, int'(rand_bits(6)), '0, '0);
    drain();
    finish_test();

    start_test("lane_skew");
    stall_en   = 1'b1;
    ready_mode = 2;
    for (int i = 0; i < 64; i++) begin
      issue(rand_bit(), int'(rand_bits(6)), wide_be_t'(rand_bits(WIDE_BW)),
            wide_data_t'(rand_bits(WIDE_DW)));
    end
    drain();
    stall_en = 1'b0;
    finish_test();

    test_backpressure();
    ready_mode = 0;

    start_test("clear");
    for (int i = 0; i < 16; i++) issue(1'b0, i, '1, wide_data_t'(rand_bits(WIDE_DW)));
    idle(8);                       // let the writes reach the banks
    @(posedge clk_i);
    #2;
    clear_i = 1'b1;
    @(posedge clk_i);
    #2;
    clear_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      compare_bit("clear r_valid_o", 1'b0, r_valid_o);
    end
    for (int i = 0; i < 16; i++) issue(1'b1, i, '0, '0);
    drain();
    finish_test();

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
split_cfg_pkg.sv
split_fsm_pkg.sv
tcdm_bank.sv
chan_fifo.sv
wide_port_split.sv
split_mem_top.sv
tb_split_mem.sv

// ==== Makefile ====
TOP  := tb_split_mem
SRCS := $(shell cat src.f)

.PHONY: run clean

obj_dir/V$(TOP): $(SRCS) src.f
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
